//--- project.f
verilog/board_cfg_pkg.sv
verilog/pad_pkg.sv
verilog/board_reset_ctrl.sv
verilog/rtc_divider.sv
verilog/fan_pwm.sv
verilog/sd_spi_pads.sv
verilog/board_top.sv
sim/tb_clk_gen.sv
sim/board_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds board_top_tb with Verilator, runs it and checks the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module board_top_tb -Mdir "$OBJ_DIR" -o board_top_tb; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/board_top_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
fi

if grep -qx "TEST OK" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

//--- sim/board_top_tb.sv
// Drives board_top through a table of reset, boot strap, RTC, fan and SD pad cases
`timescale 1ns/1ps

module board_top_tb;

  localparam int ResetStages   = 2;
  localparam int RtcHalfPeriod = 5;
  localparam int FanPrescale   = 2;
  localparam int ResetCycles   = 3;
  localparam int DriveDelay    = 1;
  localparam int FrameCycles   = 16 * FanPrescale;
  localparam int SpiCycles     = 8;
  localparam int NumRows       = 6;
  // Each row needs a little over 100 cycles
  localparam int TimeoutCycles = NumRows * 200 + 100;
  localparam logic [31:0] Seed = 32'h6e6b3e3f;

  localparam board_cfg_pkg::boot_mode_e Passive = board_cfg_pkg::BOOT_PASSIVE;
  localparam board_cfg_pkg::boot_mode_e Sd      = board_cfg_pkg::BOOT_SD;
  localparam board_cfg_pkg::boot_mode_e Flash   = board_cfg_pkg::BOOT_SPI_FLASH;
  localparam board_cfg_pkg::boot_mode_e Eeprom  = board_cfg_pkg::BOOT_I2C_EEPROM;

  // probe_len 0 means a board reset through rst_n
  typedef struct packed {
    logic                                test_mode;
    board_cfg_pkg::boot_mode_e           strap;
    board_cfg_pkg::boot_mode_e           vio_boot;
    logic                                vio_sel;
    logic [3:0]                          probe_len;
    logic [pad_pkg::FanSettingWidth-1:0] fan;
    logic [2:0]                          spi_en; // {mosi, csb, sck}
    board_cfg_pkg::boot_mode_e           exp_boot;
  } row_t;

  row_t rows [NumRows];

  logic soc_clk;
  logic por_rst_n;
  logic button_rst_n;
  logic rst_n;
  logic test_mode_i;
  board_cfg_pkg::boot_mode_e boot_mode_i;
  logic vio_reset_i;
  logic vio_boot_sel_i;
  board_cfg_pkg::boot_mode_e vio_boot_mode_i;
  logic [pad_pkg::FanSettingWidth-1:0] fan_sw_i;
  logic spih_sck_i;
  logic spih_sck_en_i;
  logic spih_csb_i;
  logic spih_csb_en_i;
  logic spih_mosi_i;
  logic spih_mosi_en_i;
  logic sd_dat0_i;
  logic soc_rst_n_o;
  board_cfg_pkg::boot_mode_e boot_mode_o;
  logic rtc_o;
  logic fan_pwm_o;
  logic sd_sclk_o;
  logic sd_dat3_o;
  logic sd_cmd_o;
  logic spih_miso_o;
  logic [31:0] rand_state;
  int cycle_cnt;
  int row_idx;

  // Board button reset on top of the power-on reset
  assign rst_n = por_rst_n & button_rst_n;

  tb_clk_gen #(
    .ClkPeriodNs ( 4           ),
    .ResetCycles ( ResetCycles ),
    .DriveDelay  ( DriveDelay  )
  ) i_clk_gen (
    .soc_clk_o ( soc_clk   ),
    .rst_n_o   ( por_rst_n )
  );

  board_top #(
    .ResetStages   ( ResetStages   ),
    .RtcHalfPeriod ( RtcHalfPeriod ),
    .FanPrescale   ( FanPrescale   )
  ) board_top_i (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .test_mode_i     ( test_mode_i     ),
    .boot_mode_i     ( boot_mode_i     ),
    .vio_reset_i     ( vio_reset_i     ),
    .vio_boot_sel_i  ( vio_boot_sel_i  ),
    .vio_boot_mode_i ( vio_boot_mode_i ),
    .fan_sw_i        ( fan_sw_i        ),
    .spih_sck_i      ( spih_sck_i      ),
    .spih_sck_en_i   ( spih_sck_en_i   ),
    .spih_csb_i      ( spih_csb_i      ),
    .spih_csb_en_i   ( spih_csb_en_i   ),
    .spih_mosi_i     ( spih_mosi_i     ),
    .spih_mosi_en_i  ( spih_mosi_en_i  ),
    .sd_dat0_i       ( sd_dat0_i       ),
    .soc_rst_n_o     ( soc_rst_n_o     ),
    .boot_mode_o     ( boot_mode_o     ),
    .rtc_o           ( rtc_o           ),
    .fan_pwm_o       ( fan_pwm_o       ),
    .sd_sclk_o       ( sd_sclk_o       ),
    .sd_dat3_o       ( sd_dat3_o       ),
    .sd_cmd_o        ( sd_cmd_o        ),
    .spih_miso_o     ( spih_miso_o     )
  );

  ////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first failed check");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_boot(input string name, input board_cfg_pkg::boot_mode_e exp,
                            input board_cfg_pkg::boot_mode_e act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%s actual=%s",
               $time, name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Outputs are sampled and inputs driven here
  task automatic wait_cycle();
    @(posedge soc_clk);
    #(DriveDelay);
  endtask

  // Blocks behind soc_rst_n_o sit at their reset levels
  task automatic confirm_reset_levels();
    check_bit("soc_rst_n_o", 1'b0, soc_rst_n_o);
    check_bit("rtc_o", 1'b0, rtc_o);
    check_bit("fan_pwm_o", 1'b0, fan_pwm_o);
    check_bit("sd_sclk_o", pad_pkg::SdIdleLevel, sd_sclk_o);
    check_bit("sd_dat3_o", pad_pkg::SdIdleLevel, sd_dat3_o);
    check_bit("sd_cmd_o", pad_pkg::SdIdleLevel, sd_cmd_o);
    check_bit("spih_miso_o", 1'b0, spih_miso_o);
  endtask

  task automatic count_release(output int edges);
    edges = 0;
    while (soc_rst_n_o !== 1'b1 && edges < 4 * ResetStages) begin
      wait_cycle();
      edges++;
    end
  endtask

  // First rise, then two high and two low half periods
  task automatic measure_rtc(input int already);
    int    edges;
    int    len;
    int    half;
    logic  level;
    string name;
    edges = already;
    while (rtc_o !== 1'b1 && edges < 4 * RtcHalfPeriod) begin
      wait_cycle();
      edges++;
    end
    check_count("rtc_o first rise", RtcHalfPeriod, edges);
    level = 1'b1;
    for (half = 0; half < 4; half++) begin
      len = 0;
      while (rtc_o === level && len < 4 * RtcHalfPeriod) begin
        wait_cycle();
        len++;
      end
      if (level) begin
        name = "rtc_o high length";
      end else begin
        name = "rtc_o low length";
      end
      check_count(name, RtcHalfPeriod, len);
      level = ~level;
    end
  endtask

  task automatic confirm_strap_hold(input board_cfg_pkg::boot_mode_e exp);
    boot_mode_i     = board_cfg_pkg::boot_mode_e'(~boot_mode_i);
    vio_boot_mode_i = board_cfg_pkg::boot_mode_e'(~vio_boot_mode_i);
    repeat (3) wait_cycle();
    check_boot("boot_mode_o after strap change", exp, boot_mode_o);
  endtask

  // Wait out the frame that latches the new setting, then count one full frame
  task automatic measure_fan_duty(input logic [pad_pkg::FanSettingWidth-1:0] fan);
    int high;
    high     = 0;
    fan_sw_i = fan;
    repeat (FrameCycles + FanPrescale) wait_cycle();
    repeat (FrameCycles) begin
      if (fan_pwm_o === 1'b1) begin
        high++;
      end
      wait_cycle();
    end
    check_count("fan_pwm_o high cycles", int'(fan) * FanPrescale, high);
  endtask

  task automatic exercise_spi_pads(input logic [2:0] en);
    logic exp_sclk;
    logic exp_dat3;
    logic exp_cmd;
    logic exp_miso;
    spih_sck_en_i  = en[0];
    spih_csb_en_i  = en[1];
    spih_mosi_en_i = en[2];
    repeat (SpiCycles) begin
      rand_state  = lcg_step(rand_state);
      spih_sck_i  = rand_state[31];
      spih_csb_i  = rand_state[30];
      spih_mosi_i = rand_state[29];
      sd_dat0_i   = rand_state[28];
      // Enabled pins carry the SoC value, others the idle level
      exp_sclk = en[0] ? spih_sck_i : pad_pkg::SdIdleLevel;
      exp_dat3 = en[1] ? spih_csb_i : pad_pkg::SdIdleLevel;
      exp_cmd  = en[2] ? spih_mosi_i : pad_pkg::SdIdleLevel;
      exp_miso = sd_dat0_i;
      wait_cycle();
      check_bit("sd_sclk_o", exp_sclk, sd_sclk_o);
      check_bit("sd_dat3_o", exp_dat3, sd_dat3_o);
      check_bit("sd_cmd_o", exp_cmd, sd_cmd_o);
      check_bit("spih_miso_o", exp_miso, spih_miso_o);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One table row
  ////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t row);
    int edges;
    boot_mode_i     = row.strap;
    vio_boot_mode_i = row.vio_boot;
    vio_boot_sel_i  = row.vio_sel;
    if (row.probe_len == 4'd0) begin
      // Test mode only changes while the board reset is held
      button_rst_n = 1'b0;
      test_mode_i  = row.test_mode;
      #(DriveDelay);
      confirm_reset_levels();
      check_boot("boot_mode_o in reset", Passive, boot_mode_o);
      repeat (ResetCycles) wait_cycle();
      button_rst_n = 1'b1;
    end else begin
      vio_reset_i = 1'b1;
      wait_cycle();
      confirm_reset_levels();
      repeat (row.probe_len - 4'd1) wait_cycle();
      vio_reset_i = 1'b0;
    end
    if (row.test_mode) begin
      // Synchronizer bypassed, straps taken on the next edge
      #(DriveDelay);
      check_bit("soc_rst_n_o in test mode", 1'b1, soc_rst_n_o);
      check_boot("boot_mode_o before capture", Passive, boot_mode_o);
      wait_cycle();
      check_boot("boot_mode_o", row.exp_boot, boot_mode_o);
      edges = 1;
    end else begin
      count_release(edges);
      check_count("soc_rst_n_o release edges", ResetStages, edges);
      check_boot("boot_mode_o", row.exp_boot, boot_mode_o);
      edges = 0;
    end
    measure_rtc(edges);
    confirm_strap_hold(row.exp_boot);
    measure_fan_duty(row.fan);
    exercise_spi_pads(row.spi_en);
  endtask

  always @(posedge soc_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("ERROR: the test table did not finish within %0d cycles", TimeoutCycles);
      abort_run();
    end
  end

  initial begin
    cycle_cnt       = 0;
    button_rst_n    = 1'b1;
    test_mode_i     = 1'b0;
    boot_mode_i     = Passive;
    vio_reset_i     = 1'b0;
    vio_boot_sel_i  = 1'b0;
    vio_boot_mode_i = Passive;
    fan_sw_i        = '0;
    spih_sck_i      = 1'b0;
    spih_sck_en_i   = 1'b0;
    spih_csb_i      = 1'b0;
    spih_csb_en_i   = 1'b0;
    spih_mosi_i     = 1'b0;
    spih_mosi_en_i  = 1'b0;
    sd_dat0_i       = 1'b0;
    rand_state      = Seed;

    // test, strap, probe boot, select, probe length, fan, SPI enables, expected boot
    rows[0] = '{1'b0, Sd,      Passive, 1'b0, 4'd0, 4'd3,  3'b111, Sd};
    rows[1] = '{1'b0, Flash,   Eeprom,  1'b1, 4'd1, 4'd15, 3'b101, Eeprom};
    rows[2] = '{1'b0, Eeprom,  Sd,      1'b1, 4'd4, 4'd0,  3'b010, Sd};
    rows[3] = '{1'b1, Flash,   Sd,      1'b0, 4'd0, 4'd8,  3'b011, Flash};
    rows[4] = '{1'b0, Passive, Flash,   1'b0, 4'd0, 4'd1,  3'b000, Passive};
    rows[5] = '{1'b0, Eeprom,  Passive, 1'b0, 4'd2, 4'd12, 3'b110, Eeprom};

    wait (por_rst_n === 1'b1);
    wait_cycle();
    for (row_idx = 0; row_idx < NumRows; row_idx++) begin
      apply_row(rows[row_idx]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

//--- sim/tb_clk_gen.sv
// Free-running soc_clk; power-on reset released a fixed drive delay after a rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ClkPeriodNs = 4,
  parameter int unsigned ResetCycles = 3,
  parameter int unsigned DriveDelay  = 1
) (
  output logic soc_clk_o,
  output logic rst_n_o
);

  initial begin
    soc_clk_o = 1'b0;
    forever begin
      #(ClkPeriodNs / 2);
      soc_clk_o = ~soc_clk_o;
    end
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge soc_clk_o);
    #(DriveDelay);
    rst_n_o = 1'b1;
  end

endmodule

//--- verilog/board_cfg_pkg.sv
// Board-level constants and state encodings; boot mode encoding must match the SoC boot ROM
package board_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Default timing of the board support blocks
  ////////////////////////////////////////////////////////////

  // soc_clk cycles per RTC half period, 50 MHz down to 1 MHz
  localparam int unsigned RtcHalfPeriodDefault = 32'd25;

  // Flop stages in the reset release synchronizer
  localparam int unsigned ResetStagesDefault = 32'd2;

  ////////////////////////////////////////////////////////////
  // Boot source selection
  ////////////////////////////////////////////////////////////

  // Same encoding as the two boot-mode DIP switches on the board
  typedef enum logic [1:0] {
    // Wait for the debugger to load a program
    BOOT_PASSIVE    = 2'd0,
    // SD card through the SPI host
    BOOT_SD         = 2'd1,
    // SPI NOR flash
    BOOT_SPI_FLASH  = 2'd2,
    // I2C EEPROM
    BOOT_I2C_EEPROM = 2'd3
  } boot_mode_e;

  ////////////////////////////////////////////////////////////
  // Reset sequencer
  ////////////////////////////////////////////////////////////

  // HOLD while any reset source is active,
  // SYNC while the release walks through the synchronizer,
  // RUN once the SoC is out of reset
  typedef enum logic [1:0] {
    RST_HOLD = 2'd0,
    RST_SYNC = 2'd1,
    RST_RUN  = 2'd2
  } rst_state_e;

endpackage

//--- verilog/board_reset_ctrl.sv
// Assumes rst_n is debounced on the board; test_mode_i bypasses the synchronizer and must be static
`timescale 1ns/1ps

module board_reset_ctrl #(
  parameter int unsigned ResetStages = 2
) (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic                    test_mode_i,
  input  logic                    vio_reset_i,
  input  logic                    vio_boot_sel_i,
  input  board_cfg_pkg::boot_mode_e boot_mode_i,
  input  board_cfg_pkg::boot_mode_e vio_boot_mode_i,
  output logic                    soc_rst_n_o,
  output board_cfg_pkg::boot_mode_e boot_mode_o
);

  logic [ResetStages-1:0] sync_d, sync_q;
  board_cfg_pkg::rst_state_e state_d, state_q;
  board_cfg_pkg::boot_mode_e boot_sel;
  board_cfg_pkg::boot_mode_e boot_mode_q;
  logic capture;

  ////////////////////////////////////////////////////////////
  // Release synchronizer
  ////////////////////////////////////////////////////////////

  // Probe reset clears the chain synchronously
  always_comb begin
    if (vio_reset_i) begin
      sync_d = '0;
    end else begin
      sync_d = ResetStages'({sync_q, 1'b1});
    end
  end

  // Test mode hands the board reset straight to the SoC
  assign soc_rst_n_o = test_mode_i ? rst_n : sync_q[ResetStages-1];

  ////////////////////////////////////////////////////////////
  // Sequencer and boot strap capture
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      board_cfg_pkg::RST_HOLD,
      board_cfg_pkg::RST_SYNC: begin
        if (test_mode_i || sync_d[ResetStages-1]) begin
          state_d = board_cfg_pkg::RST_RUN;
        end else if (vio_reset_i) begin
          state_d = board_cfg_pkg::RST_HOLD;
        end else begin
          state_d = board_cfg_pkg::RST_SYNC;
        end
      end
      board_cfg_pkg::RST_RUN: begin
        if (!test_mode_i && vio_reset_i) begin
          state_d = board_cfg_pkg::RST_HOLD;
        end
      end
      default: state_d = board_cfg_pkg::RST_HOLD;
    endcase
  end

  // Straps are taken only on the edge that releases the SoC
  assign capture  = (state_q != board_cfg_pkg::RST_RUN) && (state_d == board_cfg_pkg::RST_RUN);
  assign boot_sel = vio_boot_sel_i ? vio_boot_mode_i : boot_mode_i;

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      sync_q      <= '0;
      state_q     <= board_cfg_pkg::RST_HOLD;
      boot_mode_q <= board_cfg_pkg::BOOT_PASSIVE;
    end else begin
      sync_q  <= sync_d;
      state_q <= state_d;
      if (capture) begin
        boot_mode_q <= boot_sel;
      end
    end
  end

  assign boot_mode_o = boot_mode_q;

endmodule

//--- verilog/board_top.sv
// Board support around the SoC; clock wizard and SoC sit outside, all logic runs on soc_clk
`timescale 1ns/1ps

module board_top #(
  parameter int unsigned ResetStages   = board_cfg_pkg::ResetStagesDefault,
  parameter int unsigned RtcHalfPeriod = board_cfg_pkg::RtcHalfPeriodDefault,
  parameter int unsigned FanPrescale   = pad_pkg::FanPrescaleDefault
) (
  input  logic                              soc_clk,
  input  logic                              rst_n,
  input  logic                              test_mode_i,
  input  board_cfg_pkg::boot_mode_e         boot_mode_i,
  input  logic                              vio_reset_i,
  input  logic                              vio_boot_sel_i,
  input  board_cfg_pkg::boot_mode_e         vio_boot_mode_i,
  input  logic [pad_pkg::FanSettingWidth-1:0] fan_sw_i,
  input  logic                              spih_sck_i,
  input  logic                              spih_sck_en_i,
  input  logic                              spih_csb_i,
  input  logic                              spih_csb_en_i,
  input  logic                              spih_mosi_i,
  input  logic                              spih_mosi_en_i,
  input  logic                              sd_dat0_i,
  output logic                              soc_rst_n_o,
  output board_cfg_pkg::boot_mode_e         boot_mode_o,
  output logic                              rtc_o,
  output logic                              fan_pwm_o,
  output logic                              sd_sclk_o,
  output logic                              sd_dat3_o,
  output logic                              sd_cmd_o,
  output logic                              spih_miso_o
);

  ////////////////////////////////////////////////////////////
  // Reset and boot mode
  ////////////////////////////////////////////////////////////

  board_reset_ctrl #(
    .ResetStages ( ResetStages )
  ) i_board_reset_ctrl (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .test_mode_i     ( test_mode_i     ),
    .vio_reset_i     ( vio_reset_i     ),
    .vio_boot_sel_i  ( vio_boot_sel_i  ),
    .boot_mode_i     ( boot_mode_i     ),
    .vio_boot_mode_i ( vio_boot_mode_i ),
    .soc_rst_n_o     ( soc_rst_n_o     ),
    .boot_mode_o     ( boot_mode_o     )
  );

  ////////////////////////////////////////////////////////////
  // Blocks running on the synchronized reset
  ////////////////////////////////////////////////////////////

  rtc_divider #(
    .RtcHalfPeriod ( RtcHalfPeriod )
  ) i_rtc_divider (
    .soc_clk ( soc_clk     ),
    .rst_n   ( soc_rst_n_o ),
    .rtc_o   ( rtc_o       )
  );

  fan_pwm #(
    .FanPrescale ( FanPrescale )
  ) i_fan_pwm (
    .soc_clk   ( soc_clk     ),
    .rst_n     ( soc_rst_n_o ),
    .fan_sw_i  ( fan_sw_i    ),
    .fan_pwm_o ( fan_pwm_o   )
  );

  sd_spi_pads i_sd_spi_pads (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( soc_rst_n_o    ),
    .spih_sck_i     ( spih_sck_i     ),
    .spih_sck_en_i  ( spih_sck_en_i  ),
    .spih_csb_i     ( spih_csb_i     ),
    .spih_csb_en_i  ( spih_csb_en_i  ),
    .spih_mosi_i    ( spih_mosi_i    ),
    .spih_mosi_en_i ( spih_mosi_en_i ),
    .sd_dat0_i      ( sd_dat0_i      ),
    .sd_sclk_o      ( sd_sclk_o      ),
    .sd_dat3_o      ( sd_dat3_o      ),
    .sd_cmd_o       ( sd_cmd_o       ),
    .spih_miso_o    ( spih_miso_o    )
  );

endmodule

//--- verilog/fan_pwm.sv
// Fan setting is taken once per frame; setting 0 stops the fan and full scale is 15 of 16 steps
`timescale 1ns/1ps

module fan_pwm #(
  parameter int unsigned FanPrescale = 4
) (
  input  logic                              soc_clk,
  input  logic                              rst_n,
  input  logic [pad_pkg::FanSettingWidth-1:0] fan_sw_i,
  output logic                              fan_pwm_o
);

  localparam int unsigned PreWidth = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;
  localparam logic [PreWidth-1:0] PreLast = PreWidth'(FanPrescale - 1);

  logic [PreWidth-1:0]                 pre_d, pre_q;
  logic [pad_pkg::FanSettingWidth-1:0] step_d, step_q;
  logic [pad_pkg::FanSettingWidth-1:0] setting_d, setting_q;
  logic                                step_tick;
  logic                                pwm_q;

  assign step_tick = (pre_q == PreLast);

  always_comb begin
    pre_d     = step_tick ? '0 : pre_q + 1'b1;
    step_d    = step_q;
    setting_d = setting_q;
    if (step_tick) begin
      step_d = step_q + 1'b1;
      // Last step wraps to a new frame
      if (&step_q) begin
        setting_d = fan_sw_i;
      end
    end
  end

  // Step counter starts on the last step so the first frame
  // begins one prescale period after reset
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pre_q     <= '0;
      step_q    <= '1;
      setting_q <= '0;
      pwm_q     <= 1'b0;
    end else begin
      pre_q     <= pre_d;
      step_q    <= step_d;
      setting_q <= setting_d;
      pwm_q     <= (step_d < setting_d);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- verilog/pad_pkg.sv
// Pin-level constants for fan and SD card pads; SD idle level assumes pull-ups on the socket
package pad_pkg;

  ////////////////////////////////////////////////////////////
  // Fan control
  ////////////////////////////////////////////////////////////

  // Width of the fan switch setting, also the PWM step counter width
  // (16 steps per frame for 4 bits)
  localparam int unsigned FanSettingWidth = 32'd4;

  // soc_clk cycles per PWM step
  localparam int unsigned FanPrescaleDefault = 32'd4;

  ////////////////////////////////////////////////////////////
  // SD card in SPI mode
  ////////////////////////////////////////////////////////////

  // Level driven on SCLK, DAT3 and CMD while the SPI host
  // does not enable the pin.
  // CS is active low, so high keeps the card deselected
  localparam logic SdIdleLevel = 1'b1;

endpackage

//--- verilog/rtc_divider.sv
// RtcHalfPeriod must be at least 1; rtc_o is a divided data signal, not a clock net
`timescale 1ns/1ps

module rtc_divider #(
  parameter int unsigned RtcHalfPeriod = 25
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int unsigned CntWidth = (RtcHalfPeriod > 1) ? $clog2(RtcHalfPeriod) : 1;
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(RtcHalfPeriod - 1);

  logic [CntWidth-1:0] cnt_d, cnt_q;
  logic                rtc_d, rtc_q;

  // Wrap at the end of each half period and flip the output
  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    if (cnt_q == CntLast) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  assign rtc_o = rtc_q;

endmodule

//--- verilog/sd_spi_pads.sv
// SD card used in SPI mode only; DAT1, DAT2 and card reset are tied off outside this block
`timescale 1ns/1ps

module sd_spi_pads (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic spih_sck_i,
  input  logic spih_sck_en_i,
  input  logic spih_csb_i,
  input  logic spih_csb_en_i,
  input  logic spih_mosi_i,
  input  logic spih_mosi_en_i,
  input  logic sd_dat0_i,
  output logic sd_sclk_o,
  output logic sd_dat3_o,
  output logic sd_cmd_o,
  output logic spih_miso_o
);

  // Pin order is {CMD, DAT3, SCLK}
  logic [2:0] pin_val;
  logic [2:0] pin_en;
  logic [2:0] pin_d, pin_q;
  logic       miso_q;

  assign pin_val = {spih_mosi_i, spih_csb_i, spih_sck_i};
  assign pin_en  = {spih_mosi_en_i, spih_csb_en_i, spih_sck_en_i};

  // Disabled pins float to the idle level
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      pin_d[i] = pin_en[i] ? pin_val[i] : pad_pkg::SdIdleLevel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pad registers, meant to be packed into the IOBs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pin_q  <= {3{pad_pkg::SdIdleLevel}};
      miso_q <= 1'b0;
    end else begin
      pin_q  <= pin_d;
      miso_q <= sd_dat0_i;
    end
  end

  assign sd_sclk_o   = pin_q[0];
  assign sd_dat3_o   = pin_q[1];
  assign sd_cmd_o    = pin_q[2];
  // Card drives MISO on DAT0
  assign spih_miso_o = miso_q;

endmodule
